// File: filelist.f
hdl/rsa_arith_pkg.sv
hdl/rsa_cmd_pkg.sv
hdl/mont_mult.sv
hdl/mod_exp.sv
hdl/rsa_host_ctrl.sv
hdl/rsa_top.sv
bench/rsa_tb_sva.sv
bench/rsa_tb.sv

// File: Bender.yml
package:
  name: rsa_accel

sources:
  # Packages first, then the engines and the top level
  - hdl/rsa_arith_pkg.sv
  - hdl/rsa_cmd_pkg.sv
  - hdl/mont_mult.sv
  - hdl/mod_exp.sv
  - hdl/rsa_host_ctrl.sv
  - hdl/rsa_top.sv

  - target: test
    files:
      - bench/rsa_tb_sva.sv
      - bench/rsa_tb.sv

// File: bench/rsa_tb.sv
`default_nettype none

module rsa_tb
    import rsa_arith_pkg::*;
    import rsa_cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DONE_TIMEOUT      = 20000;
    localparam int HANDSHAKE_TIMEOUT = 100;
    localparam int MONT_SETS         = 10;
    localparam int EXP_SETS          = 9;

    logic        clk;
    logic        resetn;
    cmd_t        cmd;
    logic        cmd_valid;
    bus_t        in_data;
    logic        in_valid;
    logic        in_ready;
    bus_t        out_data;
    logic        out_valid;
    logic        out_ready;
    logic        done;
    logic        done_ack;
    logic [63:0] lcg_state;

    rsa_top uut (
        .clk       (clk),
        .resetn    (resetn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .done      (done),
        .done_ack  (done_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 64-bit LCG, upper half has the better bits
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    function automatic operand_t rand_operand();
        operand_t v;
        v[63:32] = lcg_next();
        v[31:0]  = lcg_next();
        return v;
    endfunction

    // Odd, below 2^63 and at least 3
    function automatic operand_t rand_modulus();
        operand_t m;
        m = rand_operand();
        m[OPERAND_WIDTH-1] = 1'b0;
        m[0] = 1'b1;
        if (m < operand_t'(3)) begin
            m = operand_t'(3);
        end
        return m;
    endfunction

    function automatic int rand_delay();
        return int'(lcg_next() % 32'd6);
    endfunction

    function automatic operand_t mod_mul(input operand_t a, input operand_t b, input operand_t m);
        logic [2*OPERAND_WIDTH-1:0] p;
        p = {64'b0, a} * {64'b0, b};
        return operand_t'(p % {64'b0, m});
    endfunction

    // 2^64 mod m
    function automatic operand_t r_mod(input operand_t m);
        logic [2*OPERAND_WIDTH-1:0] r;
        r = 128'd1 << OPERAND_WIDTH;
        return operand_t'(r % {64'b0, m});
    endfunction

    function automatic operand_t mod_pow(input operand_t x, input operand_t e, input operand_t m);
        operand_t acc;
        acc = operand_t'(1) % m;
        for (int i = OPERAND_WIDTH - 1; i >= 0; i--) begin
            acc = mod_mul(acc, acc, m);
            if (e[i]) begin
                acc = mod_mul(acc, x, m);
            end
        end
        return acc;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input operand_t expected,
                               input operand_t actual);
        assert (actual == expected) else begin
            fail_run($sformatf("ERROR at %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic issue_cmd(input cmd_t code);
        @(posedge clk);
        cmd       <= code;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic write_word(input bus_t word);
        int cycles;
        in_data  <= word;
        in_valid <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                fail_run("Timeout: in_ready never went high during a load");
            end
        end while (!in_ready);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Holds done_ack low for a random time once done is seen
    task automatic wait_for_done(input int limit);
        int cycles;
        int hold;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run("Timeout: done never went high");
            end
        end while (!done);
        hold = rand_delay();
        repeat (hold) @(posedge clk);
        @(posedge clk);
        done_ack <= 1'b1;
        @(posedge clk);
        done_ack <= 1'b0;
    endtask

    task automatic read_result(output operand_t value);
        int cycles;
        int hold;
        issue_cmd(CMD_READ_RESULT);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                fail_run("Timeout: out_valid never went high after a read command");
            end
        end while (!out_valid);
        hold = rand_delay();
        repeat (hold) @(posedge clk);
        @(negedge clk);
        value = out_data[OPERAND_WIDTH-1:0];
        check_value("out_data[127:64]", '0, out_data[BUS_WIDTH-1:OPERAND_WIDTH]);
        @(posedge clk);
        out_ready <= 1'b1;
        @(posedge clk);
        out_ready <= 1'b0;
        wait_for_done(HANDSHAKE_TIMEOUT);
    endtask

    task automatic load_word(input cmd_t code, input bus_t word);
        issue_cmd(code);
        write_word(word);
        wait_for_done(HANDSHAKE_TIMEOUT);
    endtask

    task automatic mont_load(input operand_t a, input operand_t b, input operand_t m);
        load_word(CMD_LOAD_AB, {b, a});
        load_word(CMD_LOAD_M, {rand_operand(), m});
    endtask

    // Result r must satisfy r * 2^64 = a * b (mod m)
    task automatic mont_run_check(input operand_t a, input operand_t b, input operand_t m);
        operand_t                   r;
        logic [2*OPERAND_WIDTH-1:0] scaled;
        issue_cmd(CMD_RUN_MONT);
        wait_for_done(DONE_TIMEOUT);
        read_result(r);
        assert (r < m) else begin
            fail_run($sformatf("ERROR at %0t: out_data expected below %h, got %h",
                               $time, m, r));
        end
        scaled = {r, 64'b0} % {64'b0, m};
        check_value("out_data * 2^64 mod m", mod_mul(a, b, m), scaled[OPERAND_WIDTH-1:0]);
    endtask

    task automatic exp_load(input operand_t x, input operand_t e, input operand_t m);
        operand_t r1;
        operand_t r2;
        r1 = r_mod(m);
        r2 = mod_mul(r1, r1, m);
        load_word(CMD_LOAD_MOD_RMOD, {r1, m});
        load_word(CMD_LOAD_R2_EXP, {e, r2});
        load_word(CMD_LOAD_X, {rand_operand(), x});
    endtask

    task automatic exp_run_check(input operand_t x, input operand_t e, input operand_t m);
        operand_t r;
        issue_cmd(CMD_RUN_EXP);
        wait_for_done(DONE_TIMEOUT);
        read_result(r);
        check_value("out_data", mod_pow(x, e, m), r);
    endtask

    always @(negedge clk) begin
        if (uut.u_sva.fail_count != 0) begin
            fail_run("A protocol assertion on the host port failed");
        end
    end

    initial begin
        int       i;
        operand_t m;
        operand_t m2;
        operand_t a;
        operand_t b;
        operand_t x;
        operand_t e;
        lcg_state = 64'd57125;
        resetn    = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        done_ack  = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        // Unknown codes leave the controller idle
        issue_cmd(32'd0);
        issue_cmd(32'd9);
        repeat (20) begin
            @(negedge clk);
            check_value("done", '0, done);
            check_value("in_ready", '0, in_ready);
            check_value("out_valid", '0, out_valid);
        end

        for (i = 0; i < MONT_SETS; i++) begin
            m = rand_modulus();
            a = (i == 0) ? '0 : rand_operand() % m;
            b = (i == 1) ? m - 1 : rand_operand() % m;
            mont_load(a, b, m);
            mont_run_check(a, b, m);
        end

        // Exponents 0, 1 and all ones below the modulus, then random ones
        for (i = 0; i < EXP_SETS; i++) begin
            m = rand_modulus();
            x = rand_operand() % m;
            if (i == 0) begin
                e = '0;
            end else if (i == 1) begin
                e = operand_t'(1);
            end else if (i == 2) begin
                m = m | (operand_t'(1) << 62);
                e = (operand_t'(1) << 62) - 1;
            end else begin
                e = rand_operand();
            end
            exp_load(x, e, m);
            exp_run_check(x, e, m);
        end

        // Each engine keeps its operands across runs of the other
        m  = rand_modulus();
        x  = rand_operand() % m;
        e  = rand_operand();
        m2 = rand_modulus();
        a  = rand_operand() % m2;
        b  = rand_operand() % m2;
        exp_load(x, e, m);
        exp_run_check(x, e, m);
        mont_load(a, b, m2);
        mont_run_check(a, b, m2);
        exp_run_check(x, e, m);
        mont_run_check(a, b, m2);

        repeat (4) @(posedge clk);
        if (uut.u_sva.fail_count != 0) begin
            fail_run("A protocol assertion on the host port failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/rsa_tb_sva.sv
`default_nettype none

module rsa_tb_sva
    import rsa_arith_pkg::*;
    import rsa_cmd_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  cmd_t cmd,
    input  logic cmd_valid,
    input  logic in_ready,
    input  bus_t out_data,
    input  logic out_valid,
    input  logic out_ready,
    input  logic done,
    input  logic done_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic cmd_seen;

    // Set by the first known command after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cmd_seen <= 1'b0;
        end else if (cmd_valid && (cmd inside {[CMD_LOAD_AB:CMD_READ_RESULT]})) begin
            cmd_seen <= 1'b1;
        end
    end

    quiet_until_cmd: assert property (@(posedge clk) disable iff (!resetn)
        !cmd_seen |-> !in_ready && !out_valid && !done)
    else begin
        $error("in_ready, out_valid or done high before any command");
        fail_count++;
    end

    done_held: assert property (@(posedge clk) disable iff (!resetn)
        done && !done_ack |=> done)
    else begin
        $error("done dropped before done_ack");
        fail_count++;
    end

    result_held: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        $error("out_valid or out_data changed before out_ready");
        fail_count++;
    end

    in_ready_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(in_ready && (out_valid || done)))
    else begin
        $error("in_ready high together with out_valid or done");
        fail_count++;
    end

endmodule

bind rsa_top rsa_tb_sva u_sva (
    .clk       (clk),
    .resetn    (resetn),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .done      (done),
    .done_ack  (done_ack)
);

`default_nettype wire

// File: hdl/rsa_top.sv
`default_nettype none

module rsa_top
    import rsa_arith_pkg::*;
    import rsa_cmd_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  cmd_t cmd,
    input  logic cmd_valid,
    input  bus_t in_data,
    input  logic in_valid,
    output logic in_ready,
    output bus_t out_data,
    output logic out_valid,
    input  logic out_ready,
    output logic done,
    input  logic done_ack
);

    mont_req_t mont_req;
    logic      mont_start;
    operand_t  mont_result;
    logic      mont_done;
    exp_req_t  exp_req;
    logic      exp_start;
    operand_t  exp_result;
    logic      exp_done;

    rsa_host_ctrl u_host_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .done        (done),
        .done_ack    (done_ack),
        .mont_req    (mont_req),
        .mont_start  (mont_start),
        .mont_result (mont_result),
        .mont_done   (mont_done),
        .exp_req     (exp_req),
        .exp_start   (exp_start),
        .exp_result  (exp_result),
        .exp_done    (exp_done)
    );

    // Directly usable multiplier
    mont_mult u_mont_mult (
        .clk    (clk),
        .resetn (resetn),
        .start  (mont_start),
        .req    (mont_req),
        .result (mont_result),
        .done   (mont_done)
    );

    // Exponentiation engine with its own private multiplier
    mod_exp u_mod_exp (
        .clk    (clk),
        .resetn (resetn),
        .start  (exp_start),
        .req    (exp_req),
        .result (exp_result),
        .done   (exp_done)
    );

endmodule

`default_nettype wire

// File: hdl/rsa_host_ctrl.sv
`default_nettype none

module rsa_host_ctrl
    import rsa_arith_pkg::*;
    import rsa_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,

    input  cmd_t      cmd,
    input  logic      cmd_valid,

    input  bus_t      in_data,
    input  logic      in_valid,
    output logic      in_ready,

    output bus_t      out_data,
    output logic      out_valid,
    input  logic      out_ready,

    output logic      done,
    input  logic      done_ack,

    output mont_req_t mont_req,
    output logic      mont_start,
    input  operand_t  mont_result,
    input  logic      mont_done,

    output exp_req_t  exp_req,
    output logic      exp_start,
    input  operand_t  exp_result,
    input  logic      exp_done
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        in_fire;
    operand_t    in_lo;
    operand_t    in_hi;
    operand_t    result_q;

    assign in_lo   = in_data[OPERAND_WIDTH-1:0];
    assign in_hi   = in_data[BUS_WIDTH-1:OPERAND_WIDTH];
    assign in_fire = in_valid && in_ready;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cmd_valid) begin
                    case (cmd)
                        CMD_LOAD_AB:       next_state = LOAD_AB;
                        CMD_LOAD_M:        next_state = LOAD_M;
                        CMD_RUN_EXP:       next_state = RUN_EXP_START;
                        CMD_RUN_MONT:      next_state = RUN_MONT_START;
                        CMD_LOAD_MOD_RMOD: next_state = LOAD_MOD_RMOD;
                        CMD_LOAD_R2_EXP:   next_state = LOAD_R2_EXP;
                        CMD_LOAD_X:        next_state = LOAD_X;
                        CMD_READ_RESULT:   next_state = SEND_RESULT;
                        // Unknown codes are dropped
                        default:           next_state = IDLE;
                    endcase
                end
            end
            LOAD_AB, LOAD_M, LOAD_MOD_RMOD, LOAD_R2_EXP, LOAD_X: begin
                if (in_fire) begin
                    next_state = SIGNAL_DONE;
                end
            end
            RUN_EXP_START: next_state = RUN_EXP;
            RUN_EXP: begin
                if (exp_done) begin
                    next_state = SIGNAL_DONE;
                end
            end
            RUN_MONT_START: next_state = RUN_MONT;
            RUN_MONT: begin
                if (mont_done) begin
                    next_state = SIGNAL_DONE;
                end
            end
            SEND_RESULT: begin
                if (out_ready) begin
                    next_state = SIGNAL_DONE;
                end
            end
            SIGNAL_DONE: begin
                if (done_ack) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Operand registers, written only in the load states
    always_ff @(posedge clk) begin
        if (in_fire) begin
            case (state)
                LOAD_AB: begin
                    mont_req.a <= in_lo;
                    mont_req.b <= in_hi;
                end
                LOAD_M: mont_req.m <= in_lo;
                LOAD_MOD_RMOD: begin
                    exp_req.modulus <= in_lo;
                    exp_req.r_mod_m <= in_hi;
                end
                LOAD_R2_EXP: begin
                    exp_req.r2_mod_m <= in_lo;
                    exp_req.exponent <= in_hi;
                end
                LOAD_X: exp_req.x <= in_lo;
                default: begin
                end
            endcase
        end
    end

    // Single result register shared by both engines
    always_ff @(posedge clk) begin
        if (state == RUN_MONT && mont_done) begin
            result_q <= mont_result;
        end else if (state == RUN_EXP && exp_done) begin
            result_q <= exp_result;
        end
    end

    assign in_ready   = state inside {LOAD_AB, LOAD_M, LOAD_MOD_RMOD, LOAD_R2_EXP, LOAD_X};
    assign out_valid  = (state == SEND_RESULT);
    assign done       = (state == SIGNAL_DONE);
    assign mont_start = (state == RUN_MONT_START);
    assign exp_start  = (state == RUN_EXP_START);
    assign out_data   = {{(BUS_WIDTH - OPERAND_WIDTH){1'b0}}, result_q};

endmodule

`default_nettype wire

// File: hdl/mod_exp.sv
`default_nettype none

module mod_exp
    import rsa_arith_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  exp_req_t req,
    output operand_t result,
    output logic     done
);

    localparam int IDX_WIDTH = $clog2(OPERAND_WIDTH);

    typedef enum logic [2:0] {
        IDLE,
        TO_MONT,
        SQUARE,
        MULTIPLY,
        FROM_MONT,
        FINISH
    } exp_state_e;

    exp_state_e           state;
    logic [IDX_WIDTH-1:0] bit_idx;
    logic                 last_bit;
    operand_t             x_mont;
    mont_req_t            mm_req;
    logic                 mm_start;
    operand_t             mm_result;
    logic                 mm_done;

    mont_mult u_mont_mult (
        .clk    (clk),
        .resetn (resetn),
        .start  (mm_start),
        .req    (mm_req),
        .result (mm_result),
        .done   (mm_done)
    );

    assign last_bit = (bit_idx == '0);

    // Sequencer, one multiplier start per step
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= IDLE;
            bit_idx  <= '0;
            mm_start <= 1'b0;
        end else begin
            mm_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        bit_idx  <= IDX_WIDTH'(OPERAND_WIDTH - 1);
                        mm_start <= 1'b1;
                        state    <= TO_MONT;
                    end
                end
                TO_MONT: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        state    <= SQUARE;
                    end
                end
                SQUARE: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        if (req.exponent[bit_idx]) begin
                            state <= MULTIPLY;
                        end else if (last_bit) begin
                            state <= FROM_MONT;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end
                MULTIPLY: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        if (last_bit) begin
                            state <= FROM_MONT;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            state   <= SQUARE;
                        end
                    end
                end
                FROM_MONT: begin
                    if (mm_done) begin
                        state <= FINISH;
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operands for the next multiplication follow the same decisions
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    mm_req <= '{a: req.x, b: req.r2_mod_m, m: req.modulus};
                end
            end
            TO_MONT: begin
                if (mm_done) begin
                    x_mont   <= mm_result;
                    // Accumulator starts as Montgomery one
                    mm_req.a <= req.r_mod_m;
                    mm_req.b <= req.r_mod_m;
                end
            end
            SQUARE: begin
                if (mm_done) begin
                    mm_req.a <= mm_result;
                    if (req.exponent[bit_idx]) begin
                        mm_req.b <= x_mont;
                    end else if (last_bit) begin
                        mm_req.b <= operand_t'(1);
                    end else begin
                        mm_req.b <= mm_result;
                    end
                end
            end
            MULTIPLY: begin
                if (mm_done) begin
                    mm_req.a <= mm_result;
                    mm_req.b <= last_bit ? operand_t'(1) : mm_result;
                end
            end
            FROM_MONT: begin
                if (mm_done) begin
                    result <= mm_result;
                end
            end
            default: begin
            end
        endcase
    end

    assign done = (state == FINISH);

endmodule

`default_nettype wire

// File: hdl/mont_mult.sv
`default_nettype none

module mont_mult
    import rsa_arith_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  mont_req_t req,
    output operand_t  result,
    output logic      done
);

    localparam int CNT_WIDTH = $clog2(OPERAND_WIDTH);

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        REDUCE,
        FINISH
    } mont_state_e;

    mont_state_e            state;
    logic [CNT_WIDTH-1:0]   bit_cnt;
    operand_t               a_shift;
    operand_t               acc;
    logic [OPERAND_WIDTH:0] sum_b;
    logic [OPERAND_WIDTH:0] sum_m;
    logic [OPERAND_WIDTH:0] diff;

    // Add b for the current bit of a, then add m to make the sum even
    always_comb begin
        sum_b = {1'b0, acc} + (a_shift[0] ? {1'b0, req.b} : '0);
        sum_m = sum_b[0] ? sum_b + {1'b0, req.m} : sum_b;
    end

    // Borrow out means acc is already below m
    assign diff = {1'b0, acc} - {1'b0, req.m};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        bit_cnt <= '0;
                        state   <= ITERATE;
                    end
                end
                ITERATE: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_WIDTH'(OPERAND_WIDTH - 1)) begin
                        state <= REDUCE;
                    end
                end
                REDUCE:  state <= FINISH;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    a_shift <= req.a;
                    acc     <= '0;
                end
            end
            ITERATE: begin
                a_shift <= a_shift >> 1;
                acc     <= sum_m[OPERAND_WIDTH:1];
            end
            REDUCE: result <= diff[OPERAND_WIDTH] ? acc : diff[OPERAND_WIDTH-1:0];
            default: begin
            end
        endcase
    end

    assign done = (state == FINISH);

endmodule

`default_nettype wire

// File: hdl/rsa_cmd_pkg.sv
`default_nettype none

package rsa_cmd_pkg;

    typedef logic [31:0] cmd_t;

    // Host command codes
    localparam cmd_t CMD_LOAD_AB       = 32'd1;
    localparam cmd_t CMD_LOAD_M        = 32'd2;
    localparam cmd_t CMD_RUN_EXP       = 32'd3;
    localparam cmd_t CMD_RUN_MONT      = 32'd4;
    localparam cmd_t CMD_LOAD_MOD_RMOD = 32'd5;
    localparam cmd_t CMD_LOAD_R2_EXP   = 32'd6;
    localparam cmd_t CMD_LOAD_X        = 32'd7;
    localparam cmd_t CMD_READ_RESULT   = 32'd8;

    // Host controller states
    typedef enum logic [3:0] {
        IDLE,
        LOAD_AB,
        LOAD_M,
        LOAD_MOD_RMOD,
        LOAD_R2_EXP,
        LOAD_X,
        RUN_EXP_START,
        RUN_EXP,
        RUN_MONT_START,
        RUN_MONT,
        SEND_RESULT,
        SIGNAL_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/rsa_arith_pkg.sv
`default_nettype none

package rsa_arith_pkg;

    // Width of one residue
    localparam int OPERAND_WIDTH = 64;

    // Host data word holds two operands
    localparam int BUS_WIDTH = 2 * OPERAND_WIDTH;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [BUS_WIDTH-1:0]     bus_t;

    // Montgomery product request for a * b * 2^-64 mod m
    typedef struct packed {
        operand_t a;
        operand_t b;
        operand_t m;
    } mont_req_t;

    // Exponentiation request with host supplied Montgomery constants
    typedef struct packed {
        operand_t modulus;
        operand_t r_mod_m;
        operand_t r2_mod_m;
        operand_t exponent;
        operand_t x;
    } exp_req_t;

endpackage

`default_nettype wire
